// File: include/spu_macros.svh
`ifndef SPU_MACROS_SVH
`define SPU_MACROS_SVH

// ----------------------------------------
// sprite engine sizing
// ----------------------------------------

// descriptor slots walked per line
`define SPU_NUM_SPRITES 16

// visible pixels per line
`define SPU_LINE_W 320

// cells per line memory, covers the 9-bit x range
`define SPU_LB_DEPTH 512

// clocks per output pixel
`define SPU_PIX_DIV 4

`endif

// File: src/spu_types_pkg.sv
package spu_types_pkg;

	// ----------------------------------------
	// sprite description
	// ----------------------------------------

	typedef enum logic [1:0]
	{
		CM_OFF = 2'd0,	// slot unused
		CM_4C  = 2'd1,	// 2 bits per pixel, 8 pixels per word
		CM_16C = 2'd2	// 4 bits per pixel, 4 pixels per word
	} colour_mode_t;

	// descriptor, 60 bits, lives in the low bits of a config write
	typedef struct packed
	{
		logic [8:0]   x_pos;	// left edge on the line
		logic [8:0]   y_pos;	// first line
		logic [5:0]   height;	// lines
		logic [7:0]   width;	// dram words per row
		logic [20:0]  base;		// word address of row 0
		logic [3:0]   bank;		// palette bank
		logic         flip_x;
		colour_mode_t mode;
	} sprite_desc_t;

	// ----------------------------------------
	// pixels
	// ----------------------------------------

	typedef struct packed
	{
		logic       transparent;	// pixel not drawn
		logic [5:0] colour;
	} pal_entry_t;

	// one line buffer cell
	typedef struct packed
	{
		logic       valid;	// a sprite pixel landed here
		logic [5:0] colour;
	} line_pix_t;

	typedef struct packed
	{
		logic       strobe;	// one clock per output pixel
		logic       en;		// sprite pixel present
		logic [5:0] colour;
	} spu_out_t;

endpackage

// File: src/spu_bus_pkg.sv
package spu_bus_pkg;

	// ----------------------------------------
	// dram read channel
	// ----------------------------------------

	typedef struct packed
	{
		logic [20:0] addr;	// word address
	} dram_req_t;

	typedef struct packed
	{
		logic        valid;	// one cycle per accepted request
		logic [15:0] data;
	} dram_rsp_t;

	// ----------------------------------------
	// host config port
	// ----------------------------------------

	typedef enum logic
	{
		CFG_SPRITE  = 1'b0,	// descriptor file
		CFG_PALETTE = 1'b1	// palette ram
	} cfg_target_t;

	typedef struct packed
	{
		logic        valid;
		cfg_target_t target;
		logic [7:0]  idx;	// sprite number or bank*16+colour
		logic [63:0] data;	// payload in the low bits
	} cfg_wr_t;

endpackage

// File: src/spu_ram.sv
`timescale 1ns/1ps

// simple dual port ram, one write port and one registered read port
module spu_ram #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 16
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  entry_t                   wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output entry_t                   rdata
);

	entry_t mem [DEPTH];

	// ----------------------------------------
	// write port
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// ----------------------------------------
	// read port, data one clock after raddr
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];	// read-before-write on collision
	end

endmodule

// File: src/sline_buffer.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

// ping-pong sprite line buffer
// wsel picks the half that takes sprite pixels, the other half is read out and cleared
module sline_buffer (
	input  logic                     clk,
	input  logic                     line_start,
	input  logic                     wsel,
	input  logic                     wr_en,
	input  logic [8:0]               wr_addr,
	input  spu_types_pkg::line_pix_t wr_pix,
	output spu_types_pkg::spu_out_t  pix_out
);

	localparam int              PH_W    = $clog2(`SPU_PIX_DIV);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(`SPU_PIX_DIV - 1);

	spu_types_pkg::line_pix_t mem0 [`SPU_LB_DEPTH];
	spu_types_pkg::line_pix_t mem1 [`SPU_LB_DEPTH];
	spu_types_pkg::line_pix_t rd_q;	// cell fetched in phase 0

	logic [PH_W-1:0] ph;		// position inside the pixel slot
	logic [8:0]      rd_ptr;	// readout address
	logic            sweep;		// readout still running
	logic            clr_we;	// clear the cell just shown

	assign sweep  = (rd_ptr < 9'(`SPU_LINE_W));
	assign clr_we = sweep && (ph == PH_W'(2));

	// ----------------------------------------
	// readout pacing
	// ----------------------------------------

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			ph      <= '0;
			rd_ptr  <= '0;
			pix_out <= '0;
		end
		else if (sweep)
		begin
			if (ph == PH_LAST)
			begin
				ph     <= '0;
				rd_ptr <= rd_ptr + 9'd1;	// next cell
			end
			else
				ph <= ph + 1'b1;

			// phase 1, present the cell read in phase 0
			if (ph == PH_W'(1))
				pix_out <= '{strobe: 1'b1, en: rd_q.valid, colour: rd_q.colour};
			else
				pix_out.strobe <= 1'b0;	// colour held for the mixer
		end
	end

	// registered read of the readout half
	always_ff @(posedge clk)
	begin
		if (sweep && (ph == '0))
			rd_q <= wsel ? mem0[rd_ptr] : mem1[rd_ptr];
	end

	// ----------------------------------------
	// write ports, sprite pixels or clear
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (!wsel && wr_en)
			mem0[wr_addr] <= wr_pix;
		else if (wsel && clr_we)
			mem0[rd_ptr] <= '0;	// behind the read
	end

	always_ff @(posedge clk)
	begin
		if (wsel && wr_en)
			mem1[wr_addr] <= wr_pix;
		else if (!wsel && clr_we)
			mem1[rd_ptr] <= '0;
	end

endmodule

// File: src/sprite_fetch.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

// per line sprite walker
// reads each descriptor, fetches the visible row from dram, decodes pixels,
// looks them up in the palette and writes opaque ones into the line buffer
module sprite_fetch (
	input  logic                                clk,
	input  logic                                line_start,
	input  logic [8:0]                          vline,
	input  spu_types_pkg::sprite_desc_t         desc_rd,
	input  spu_types_pkg::pal_entry_t           pal_rd,
	input  logic                                dram_req_ready,
	input  spu_bus_pkg::dram_rsp_t              dram_rsp,
	output logic [$clog2(`SPU_NUM_SPRITES)-1:0] desc_addr,
	output logic [7:0]                          pal_addr,
	output spu_bus_pkg::dram_req_t              dram_req,
	output logic                                dram_req_valid,
	output logic                                lb_wr_en,
	output logic [8:0]                          lb_wr_addr,
	output spu_types_pkg::line_pix_t            lb_wr_pix,
	output logic                                done
);

	localparam int NUM_W = $clog2(`SPU_NUM_SPRITES);

	typedef enum logic [2:0]
	{
		S_ADDR,	// descriptor read in flight
		S_TEST,	// descriptor valid, visibility test
		S_REQ,	// dram request held
		S_WAIT,	// waiting for the word
		S_PIX,	// one pixel per clock
		S_DONE
	} state_t;

	state_t     state;
	logic [NUM_W-1:0] num;		// current sprite
	logic       last_spr;

	// latched from the descriptor
	spu_types_pkg::colour_mode_t mode_q;
	logic [3:0]  bank_q;
	logic        flip_q;

	logic [20:0] word_addr;	// next dram word
	logic [7:0]  words_left;
	logic [11:0] xpos;		// wide, so off-line positions are just dropped
	logic [15:0] shreg;		// pixels leave from the top
	logic [3:0]  pix_left;
	logic [3:0]  pix_idx;

	// palette pipeline stage
	logic        pend_valid;
	logic [11:0] pend_x;

	// descriptor test terms
	logic        spr_vis;
	logic [9:0]  y_end;
	logic [8:0]  row_full;
	logic [13:0] row_ofs;
	logic [20:0] row_addr;
	logic [10:0] wpix;
	logic [11:0] x_start;

	// ----------------------------------------
	// descriptor decode
	// ----------------------------------------

	assign y_end    = {1'b0, desc_rd.y_pos} + 10'(desc_rd.height);
	assign spr_vis  = ((desc_rd.mode == spu_types_pkg::CM_4C)
		|| (desc_rd.mode == spu_types_pkg::CM_16C))
		&& (desc_rd.width != 8'd0)
		&& (vline >= desc_rd.y_pos)
		&& ({1'b0, vline} < y_end);
	assign row_full = vline - desc_rd.y_pos;
	assign row_ofs  = row_full[5:0] * desc_rd.width;	// row within sprite times width
	assign row_addr = desc_rd.base + 21'(row_ofs);
	// row width in pixels
	assign wpix     = (desc_rd.mode == spu_types_pkg::CM_4C) ?
		{desc_rd.width, 3'b000} : {1'b0, desc_rd.width, 2'b00};
	// flipped rows are drawn right to left from the far edge
	assign x_start  = desc_rd.flip_x ?
		({3'b000, desc_rd.x_pos} + {1'b0, wpix} - 12'd1) : {3'b000, desc_rd.x_pos};

	assign last_spr = (num == NUM_W'(`SPU_NUM_SPRITES - 1));

	// ----------------------------------------
	// control
	// ----------------------------------------

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state      <= S_ADDR;
			num        <= '0;
			pend_valid <= 1'b0;
		end
		else
		begin
			pend_valid <= (state == S_PIX);	// palette answers next clock
			case (state)
				S_ADDR:
					state <= S_TEST;
				S_TEST:
					if (spr_vis)
						state <= S_REQ;
					else if (last_spr)
						state <= S_DONE;
					else
					begin
						num   <= num + 1'b1;
						state <= S_ADDR;
					end
				S_REQ:
					if (dram_req_ready)
						state <= S_WAIT;
				S_WAIT:
					if (dram_rsp.valid)
						state <= S_PIX;
				S_PIX:
					if (pix_left == 4'd1)
					begin
						// word finished
						if (words_left != 8'd1)
							state <= S_REQ;
						else if (last_spr)
							state <= S_DONE;
						else
						begin
							num   <= num + 1'b1;
							state <= S_ADDR;
						end
					end
				S_DONE:
					state <= S_DONE;	// parked until next line
				default:
					state <= S_DONE;
			endcase
		end
	end

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		case (state)
			S_TEST:
				if (spr_vis)
				begin
					mode_q     <= desc_rd.mode;
					bank_q     <= desc_rd.bank;
					flip_q     <= desc_rd.flip_x;
					word_addr  <= row_addr;
					words_left <= desc_rd.width;
					xpos       <= x_start;
				end
			S_WAIT:
				if (dram_rsp.valid)
				begin
					shreg     <= dram_rsp.data;
					pix_left  <= (mode_q == spu_types_pkg::CM_4C) ? 4'd8 : 4'd4;
					word_addr <= word_addr + 21'd1;
				end
			S_PIX:
			begin
				shreg    <= (mode_q == spu_types_pkg::CM_4C) ? (shreg << 2) : (shreg << 4);
				pix_left <= pix_left - 4'd1;
				pend_x   <= xpos;
				xpos     <= flip_q ? (xpos - 12'd1) : (xpos + 12'd1);
				if (pix_left == 4'd1)
					words_left <= words_left - 8'd1;
			end
			default:
			begin
			end
		endcase
	end

	// palette index from the top of the word
	assign pix_idx  = (mode_q == spu_types_pkg::CM_4C) ? {2'b00, shreg[15:14]} : shreg[15:12];
	assign pal_addr = {bank_q, pix_idx};

	// ----------------------------------------
	// outputs
	// ----------------------------------------

	assign desc_addr      = num;
	assign dram_req.addr  = word_addr;
	assign dram_req_valid = (state == S_REQ);
	assign done           = (state == S_DONE);

	// transparent and off-line pixels are skipped
	assign lb_wr_en   = pend_valid && !pal_rd.transparent && (pend_x < 12'(`SPU_LINE_W));
	assign lb_wr_addr = pend_x[8:0];
	assign lb_wr_pix  = '{valid: 1'b1, colour: pal_rd.colour};

endmodule

// File: src/sprite_unit.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

// sprite layer top
module sprite_unit (
	input  logic                    clk,
	input  logic                    line_start,
	input  logic [8:0]              vline,
	input  spu_bus_pkg::cfg_wr_t    cfg,
	input  logic                    dram_req_ready,
	input  spu_bus_pkg::dram_rsp_t  dram_rsp,
	output spu_bus_pkg::dram_req_t  dram_req,
	output logic                    dram_req_valid,
	output spu_types_pkg::spu_out_t pix_out,
	output logic                    done
);

	localparam int NUM_W     = $clog2(`SPU_NUM_SPRITES);
	localparam int PAL_DEPTH = 256;	// 16 banks of 16 colours

	logic                        desc_we;
	logic                        pal_we;
	logic [NUM_W-1:0]            desc_addr;
	logic [7:0]                  pal_addr;
	spu_types_pkg::sprite_desc_t desc_rd;
	spu_types_pkg::pal_entry_t   pal_rd;
	logic                        lb_wr_en;
	logic [8:0]                  lb_wr_addr;
	spu_types_pkg::line_pix_t    lb_wr_pix;

	// ----------------------------------------
	// config decode
	// ----------------------------------------

	assign desc_we = cfg.valid && (cfg.target == spu_bus_pkg::CFG_SPRITE);
	assign pal_we  = cfg.valid && (cfg.target == spu_bus_pkg::CFG_PALETTE);

	spu_ram #(
		.entry_t (spu_types_pkg::sprite_desc_t),
		.DEPTH   (`SPU_NUM_SPRITES)
	) desc_ram0 (
		.clk   (clk),
		.we    (desc_we),
		.waddr (cfg.idx[NUM_W-1:0]),
		.wdata (spu_types_pkg::sprite_desc_t'(cfg.data[$bits(spu_types_pkg::sprite_desc_t)-1:0])),
		.raddr (desc_addr),
		.rdata (desc_rd)
	);

	spu_ram #(
		.entry_t (spu_types_pkg::pal_entry_t),
		.DEPTH   (PAL_DEPTH)
	) pal_ram0 (
		.clk   (clk),
		.we    (pal_we),
		.waddr (cfg.idx),
		.wdata (spu_types_pkg::pal_entry_t'(cfg.data[$bits(spu_types_pkg::pal_entry_t)-1:0])),
		.raddr (pal_addr),
		.rdata (pal_rd)
	);

	// ----------------------------------------
	// fetch engine and line buffer
	// ----------------------------------------

	sprite_fetch sprite_fetch0 (
		.clk            (clk),
		.line_start     (line_start),
		.vline          (vline),
		.desc_rd        (desc_rd),
		.pal_rd         (pal_rd),
		.dram_req_ready (dram_req_ready),
		.dram_rsp       (dram_rsp),
		.desc_addr      (desc_addr),
		.pal_addr       (pal_addr),
		.dram_req       (dram_req),
		.dram_req_valid (dram_req_valid),
		.lb_wr_en       (lb_wr_en),
		.lb_wr_addr     (lb_wr_addr),
		.lb_wr_pix      (lb_wr_pix),
		.done           (done)
	);

	sline_buffer sline_buffer0 (
		.clk        (clk),
		.line_start (line_start),
		.wsel       (vline[0]),	// odd lines fill half 1
		.wr_en      (lb_wr_en),
		.wr_addr    (lb_wr_addr),
		.wr_pix     (lb_wr_pix),
		.pix_out    (pix_out)
	);

endmodule

// File: testbench/dram_model.sv
`timescale 1ns/1ps

// behavioural dram with one read in flight and random ready stalls and latency
module dram_model #(
	parameter int AW = 12	// word address bits actually stored
) (
	input  logic                   clk,
	input  spu_bus_pkg::dram_req_t req,
	input  logic                   req_valid,
	output logic                   req_ready,
	output spu_bus_pkg::dram_rsp_t rsp
);

	logic [15:0] mem [2**AW];	// preloaded by the testbench
	int          seed;
	logic        seeded;		// random stream started
	logic        fire;			// handshake seen at the coming edge
	logic [20:0] addr_n;
	logic [20:0] addr_q;		// address of the read in flight
	logic        busy;
	int          wait_cnt;		// cycles left before the answer

	initial
	begin
		seed = 32'h706828e9;
		for (int i = 0; i < 2**AW; i++)
			mem[i] = 16'(i) ^ 16'ha5a5;	// unloaded words differ per address
		seeded    = 1'b0;
		busy      = 1'b0;
		wait_cnt  = 0;
		fire      = 1'b0;
		addr_n    = '0;
		addr_q    = '0;
		req_ready = 1'b0;
		rsp       = '0;
	end

	// ----------------------------------------
	// sample the request side mid cycle
	// ----------------------------------------

	always @(negedge clk)
	begin
		fire   = req_valid && req_ready;
		addr_n = req.addr;
	end

	// drive ready and response just after the edge
	always @(posedge clk)
	begin
		if (!seeded)
		begin
			void'($urandom(seed));	// one seed for the whole run
			seeded = 1'b1;
		end
		#1;
		rsp.valid = 1'b0;
		if (busy)
		begin
			if (wait_cnt == 0)
			begin
				rsp.valid = 1'b1;
				rsp.data  = mem[addr_q[AW-1:0]];
				busy      = 1'b0;
			end
			else
				wait_cnt--;
		end
		else if (fire)
		begin
			busy     = 1'b1;
			addr_q   = addr_n;
			wait_cnt = $urandom % 5;	// 0 to 4 extra cycles
		end
		req_ready = !busy && (($urandom % 4) != 0);	// stall about one cycle in four
	end

endmodule

// File: testbench/sprite_unit_tb.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module sprite_unit_tb;

	localparam int LINE_CYCLES = 1400;	// clocks per video line
	localparam int MAX_LINES   = 32;
	localparam int MAX_CFG     = 64;
	localparam int MAX_WORDS   = 64;
	localparam int DRAM_AW     = 12;

	logic                    clk;
	logic                    line_start;
	logic [8:0]              vline;
	spu_bus_pkg::cfg_wr_t    cfg;
	logic                    dram_req_ready;
	spu_bus_pkg::dram_rsp_t  dram_rsp;
	spu_bus_pkg::dram_req_t  dram_req;
	logic                    dram_req_valid;
	spu_types_pkg::spu_out_t pix_out;
	logic                    done;

	// parsed stim file
	spu_bus_pkg::cfg_wr_t    cfg_list [MAX_CFG];
	logic [20:0]             word_addr [MAX_WORDS];
	logic [15:0]             word_data [MAX_WORDS];
	logic [8:0]              line_vl [MAX_LINES];
	logic                    line_chk [MAX_LINES];	// 0 for warm-up lines
	int                      line_fill [MAX_LINES];	// expected pixels given
	spu_types_pkg::spu_out_t exp_pix [MAX_LINES*`SPU_LINE_W];
	int                      num_cfg;
	int                      num_words;
	int                      num_lines;

	int cur_line;	// -1 before the first line
	int pix_cnt;	// strobes seen on this line
	int cycles;
	int cycle_limit;

	logic                   req_stalled;	// request seen waiting for ready
	spu_bus_pkg::dram_req_t req_last;

	always #2 clk = ~clk;	// 4 ns period

	sprite_unit dut0 (
		.clk            (clk),
		.line_start     (line_start),
		.vline          (vline),
		.cfg            (cfg),
		.dram_req_ready (dram_req_ready),
		.dram_rsp       (dram_rsp),
		.dram_req       (dram_req),
		.dram_req_valid (dram_req_valid),
		.pix_out        (pix_out),
		.done           (done)
	);

	dram_model #(
		.AW (DRAM_AW)
	) dram0 (
		.clk       (clk),
		.req       (dram_req),
		.req_valid (dram_req_valid),
		.req_ready (dram_req_ready),
		.rsp       (dram_rsp)
	);

	// ----------------------------------------
	// failure and compare tasks
	// ----------------------------------------

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pix(input spu_types_pkg::spu_out_t got,
		input spu_types_pkg::spu_out_t exp, input int x);
		if ((got.en !== exp.en) || (got.colour !== exp.colour))
			stop_run($sformatf("error: t=%0t pix_out line %0d x %0d got en %b colour %h, %s%b %s%h",
				$time, cur_line, x, got.en, got.colour,
				"expected en ", exp.en, "colour ", exp.colour));
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("error: t=%0t done got %b expected %b", $time, got, exp));
	endtask

	task automatic check_req_valid(input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("error: t=%0t dram_req_valid got %b expected %b",
				$time, got, exp));
	endtask

	task automatic check_req(input spu_bus_pkg::dram_req_t got,
		input spu_bus_pkg::dram_req_t exp);
		if (got !== exp)
			stop_run($sformatf("error: t=%0t dram_req.addr got %h expected %h",
				$time, got.addr, exp.addr));
	endtask

	// ----------------------------------------
	// stim file
	// ----------------------------------------

	task automatic add_cfg(input spu_bus_pkg::cfg_target_t target, input int idx,
		input logic [63:0] data);
		spu_bus_pkg::cfg_wr_t w;
		if (num_cfg >= MAX_CFG)
			stop_run("too many config writes in the stim file");
		w.valid  = 1'b1;
		w.target = target;
		w.idx    = 8'(idx);
		w.data   = data;
		cfg_list[num_cfg] = w;
		num_cfg++;
	endtask

	task automatic read_stim();
		int                          fd;
		int                          n;
		int                          c;
		int                          idx;
		int                          x;
		int                          y;
		int                          h;
		int                          w;
		int                          bank;
		int                          flip;
		int                          mode;
		int                          cnt;
		int                          en;
		int                          chk;
		int                          slot;
		logic [7:0]                  tag;
		logic [20:0]                 addr;
		logic [15:0]                 data;
		logic [5:0]                  col;
		spu_types_pkg::sprite_desc_t d;
		spu_types_pkg::pal_entry_t   pe;
		spu_types_pkg::spu_out_t     p;
		num_cfg   = 0;
		num_words = 0;
		num_lines = 0;
		// every slot starts switched off
		for (int i = 0; i < `SPU_NUM_SPRITES; i++)
			add_cfg(spu_bus_pkg::CFG_SPRITE, i, 64'd0);
		fd = $fopen("testbench/sprite_stim.txt", "r");
		if (fd == 0)
			stop_run("cannot open testbench/sprite_stim.txt");
		while (!$feof(fd))
		begin
			n = $fscanf(fd, " %c", tag);
			if (n != 1)
				break;
			case (tag)
				"#":
				begin
					c = $fgetc(fd);
					while ((c != 10) && (c != -1))
						c = $fgetc(fd);
				end
				"s":
				begin
					n = $fscanf(fd, "%d %d %d %d %d %h %d %d %d",
						idx, x, y, h, w, addr, bank, flip, mode);
					if (n != 9)
						stop_run("malformed sprite record in the stim file");
					d.x_pos  = 9'(x);
					d.y_pos  = 9'(y);
					d.height = 6'(h);
					d.width  = 8'(w);
					d.base   = addr;
					d.bank   = 4'(bank);
					d.flip_x = flip[0];
					d.mode   = spu_types_pkg::colour_mode_t'(mode);
					add_cfg(spu_bus_pkg::CFG_SPRITE, idx, {4'b0, d});
				end
				"p":
				begin
					n = $fscanf(fd, "%h %d %h", idx, en, col);
					if (n != 3)
						stop_run("malformed palette record in the stim file");
					pe.transparent = en[0];
					pe.colour      = col;
					add_cfg(spu_bus_pkg::CFG_PALETTE, idx, {57'b0, pe});
				end
				"m":
				begin
					n = $fscanf(fd, "%h %h", addr, data);
					if ((n != 2) || (num_words >= MAX_WORDS))
						stop_run("bad dram word record in the stim file");
					word_addr[num_words] = addr;
					word_data[num_words] = data;
					num_words++;
				end
				"l":
				begin
					n = $fscanf(fd, "%d %d", y, chk);
					if ((n != 2) || (num_lines >= MAX_LINES))
						stop_run("bad line record in the stim file");
					line_vl[num_lines]   = 9'(y);
					line_chk[num_lines]  = chk[0];
					line_fill[num_lines] = 0;
					num_lines++;
				end
				"r":
				begin
					n = $fscanf(fd, "%d %d %h", cnt, en, col);
					if ((n != 3) || (num_lines == 0))
						stop_run("bad pixel run in the stim file");
					slot     = num_lines - 1;
					p.strobe = 1'b1;
					p.en     = en[0];
					p.colour = col;
					for (int k = 0; k < cnt; k++)
					begin
						if (line_fill[slot] >= `SPU_LINE_W)
							stop_run("pixel runs longer than a line in the stim file");
						exp_pix[slot*`SPU_LINE_W + line_fill[slot]] = p;
						line_fill[slot]++;
					end
				end
				default:
					stop_run("unknown record in the stim file");
			endcase
		end
		$fclose(fd);
		for (int i = 0; i < num_lines; i++)
			if (line_chk[i] && (line_fill[i] != `SPU_LINE_W))
				stop_run($sformatf("stim line %0d does not give a full line of pixels", i));
	endtask

	// ----------------------------------------
	// drive tasks set inputs 1 ns after the edge
	// ----------------------------------------

	task automatic write_cfg(input spu_bus_pkg::cfg_wr_t w);
		@(posedge clk);
		#1 cfg = w;
	endtask

	task automatic run_line(input int i);
		@(posedge clk);
		#1;
		line_start = 1'b1;
		vline      = line_vl[i];
		cur_line   = i;
		pix_cnt    = 0;
		repeat (2) @(posedge clk);
		#1 line_start = 1'b0;
		repeat (LINE_CYCLES - 3) @(posedge clk);
		@(negedge clk);	// outputs settled
		if (pix_cnt != `SPU_LINE_W)
			stop_run($sformatf("line %0d showed %0d pixels instead of %0d",
				i, pix_cnt, `SPU_LINE_W));
		check_done(done, 1'b1);	// fetch over before the next line_start
	endtask

	// ----------------------------------------
	// pixel monitor and timeout
	// ----------------------------------------

	always @(negedge clk)
	begin
		if (!line_start && (pix_out.strobe === 1'b1) && (cur_line >= 0))
		begin
			if (pix_cnt >= `SPU_LINE_W)
				stop_run("more pixel strobes than the line width");
			else if (line_chk[cur_line])
				check_pix(pix_out, exp_pix[cur_line*`SPU_LINE_W + pix_cnt], pix_cnt);
			pix_cnt = pix_cnt + 1;
		end
	end

	// stalled request stays valid on the same address, line_start drops it
	always @(negedge clk)
	begin
		if (line_start)
			check_req_valid(dram_req_valid, 1'b0);
		else if (req_stalled)
		begin
			check_req_valid(dram_req_valid, 1'b1);
			check_req(dram_req, req_last);
		end
		req_stalled = !line_start && (dram_req_valid === 1'b1) && (dram_req_ready === 1'b0);
		req_last    = dram_req;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			stop_run("timeout, the run went past its cycle limit");
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial
	begin
		clk         = 1'b0;
		line_start  = 1'b1;
		vline       = '0;
		cfg         = '0;
		cur_line    = -1;
		pix_cnt     = 0;
		cycles      = 0;
		cycle_limit = 100;
		req_stalled = 1'b0;
		req_last    = '0;
		read_stim();
		cycle_limit = num_lines * LINE_CYCLES + num_cfg + 100;
		repeat (2) @(posedge clk);
		#1 line_start = 1'b0;
		for (int i = 0; i < num_words; i++)
			dram0.mem[word_addr[i][DRAM_AW-1:0]] = word_data[i];
		for (int i = 0; i < num_cfg; i++)
			write_cfg(cfg_list[i]);
		@(posedge clk);
		#1 cfg = '0;
		for (int i = 0; i < num_lines; i++)
			run_line(i);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
src/spu_types_pkg.sv
src/spu_bus_pkg.sv
src/spu_ram.sv
src/sline_buffer.sv
src/sprite_fetch.sv
src/sprite_unit.sv
testbench/dram_model.sv
testbench/sprite_unit_tb.sv

// File: testbench/sprite_stim.txt
# s idx x y height width base(hex) bank flip mode | p index(hex) transparent colour(hex)
# m addr(hex) data(hex) | l vline check | r count enable colour(hex), runs fill 320 pixels
# sprites, mode 1 is 4-colour, mode 2 is 16-colour
s 0 10 4 8 2 100 1 0 1
s 1 40 4 2 1 200 2 0 2
s 2 100 5 1 1 300 3 1 1
s 3 14 4 1 1 400 4 0 1
# palette banks 1 to 4, bank 4 colour 0 is transparent
p 10 0 11  p 11 0 12  p 12 0 13  p 13 0 14
p 21 0 21  p 22 0 22  p 23 0 23  p 24 0 24
p 30 0 30  p 31 0 31  p 32 0 32  p 33 0 33
p 40 1 00  p 41 0 0a
# sprite 0, rows 0 to 7, two words per row
m 100 0000  m 101 0000
m 102 5555  m 103 0000
m 104 aaaa  m 105 5555
m 106 ffff  m 107 5555
m 108 0000  m 109 aaaa
m 10a 5555  m 10b aaaa
m 10c aaaa  m 10d ffff
m 10e ffff  m 10f ffff
# sprite 1 rows 0 and 1, sprite 2, sprite 3
m 200 1234  m 201 4321
m 300 1b00
m 400 5050
# each line shows what the line before it fetched, lines 0 and 1 warm up
l 0 0
l 1 0
l 2 1  r 320 0 00
l 3 1  r 320 0 00
l 4 1  r 320 0 00
# sprite 0 row 0 under sprite 3, sprite 1 row 0
l 5 1  r 10 0 00  r 4 1 11  r 2 1 0a  r 2 1 11  r 2 1 0a  r 6 1 11  r 14 0 00
       r 1 1 21  r 1 1 22  r 1 1 23  r 1 1 24  r 276 0 00
# row 1 of sprites 0 and 1, sprite 2 mirrored
l 6 1  r 10 0 00  r 8 1 12  r 8 1 11  r 14 0 00
       r 1 1 24  r 1 1 23  r 1 1 22  r 1 1 21  r 56 0 00
       r 4 1 30  r 1 1 33  r 1 1 32  r 1 1 31  r 1 1 30  r 212 0 00
# sprite 0 rows 2 to 7
l 7 1  r 10 0 00  r 8 1 13  r 8 1 12  r 294 0 00
l 8 1  r 10 0 00  r 8 1 14  r 8 1 12  r 294 0 00
l 9 1  r 10 0 00  r 8 1 11  r 8 1 13  r 294 0 00
l 10 1  r 10 0 00  r 8 1 12  r 8 1 13  r 294 0 00
l 11 1  r 10 0 00  r 8 1 13  r 8 1 14  r 294 0 00
l 12 1  r 10 0 00  r 8 1 14  r 8 1 14  r 294 0 00
# below sprite 0, the buffer half must come back empty
l 13 1  r 320 0 00
